//--- common/neuron_pe_consts.svh
//--------------------------------------------------------------------------
// neuron processing element constants
// buffer depths, data width and the timing of the four-cycle operations
// shared by the package and by every block of the element
//--------------------------------------------------------------------------

`ifndef NEURON_PE_CONSTS_SVH
`define NEURON_PE_CONSTS_SVH

// data word width, used for data, weights and the accumulator
`define PE_DATA_W 32

// circular weight store entries
`define PE_WGT_DEPTH 16

// input recording buffer entries
`define PE_IN_DEPTH 8

// finished neuron values waiting for readout
`define PE_OUT_DEPTH 4

// count on which a timed operation commits
// a timed operation therefore lasts PE_OP_LAST + 1 cycles
`define PE_OP_LAST 3

// operation counter width
`define PE_CNT_W 2

`endif

//--- common/neuron_pe_pkg.sv
//--------------------------------------------------------------------------
// neuron processing element types
// data words, store indices, the opcode enum and the per-cycle step
// that the sequencer hands to every consumer
//--------------------------------------------------------------------------

`include "neuron_pe_consts.svh"

package neuron_pe_pkg;

	// signed word for data, weights and accumulator
	typedef logic signed [`PE_DATA_W-1:0] pe_word_t;

	// store indices
	typedef logic [$clog2(`PE_WGT_DEPTH)-1:0] wgt_idx_t;
	typedef logic [$clog2(`PE_IN_DEPTH)-1:0]  in_idx_t;
	typedef logic [$clog2(`PE_OUT_DEPTH)-1:0] out_idx_t;

	// operation cycle count
	typedef logic [`PE_CNT_W-1:0] pe_cnt_t;

	// controller opcodes, code 4 was output forwarding and is now a no-op
	typedef enum logic [2:0] {
		op_idle    = 3'd0,
		op_load    = 3'd1,
		op_ma      = 3'd2,
		op_mab     = 3'd3,
		op_nop     = 3'd4,
		op_bias    = 3'd5,
		op_act     = 3'd6,
		op_act_clr = 3'd7
	} pe_op_t;

	// held opcode plus first and last cycle strobes of a timed operation
	typedef struct packed {
		pe_op_t op;
		logic   issue;
		logic   commit;
	} pe_step_t;

endpackage

//--- src/op_sequencer.sv
//--------------------------------------------------------------------------
// operation sequencer
// counts the cycles of a held timed opcode and turns the count into
// issue and commit strobes for the stores, the accumulator and the
// output buffer
//--------------------------------------------------------------------------

`include "neuron_pe_consts.svh"

module op_sequencer
	import neuron_pe_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  pe_op_t   ctrl,
	output pe_step_t step
);

	pe_cnt_t cnt;
	pe_cnt_t cnt_nxt;
	logic    timed;
	logic    last;

	// load writes every cycle and nop does nothing, neither is counted
	always_comb
	begin
		case (ctrl)
			op_load,
			op_nop:  timed = 1'b0;
			default: timed = 1'b1;
		endcase
	end

	assign last = (cnt == pe_cnt_t'(`PE_OP_LAST));

	// a run of the same opcode simply restarts at zero
	always_comb
	begin
		if (!timed || last)
			cnt_nxt = '0;
		else
			cnt_nxt = cnt + pe_cnt_t'(1);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			cnt <= '0;
		else
			cnt <= cnt_nxt;
	end

	//--------------------------------------------------------------------------
	// step to the consumers
	//--------------------------------------------------------------------------

	// opcode passes straight through
	assign step.op     = ctrl;
	assign step.issue  = timed && (cnt == '0);
	assign step.commit = timed && last;

endmodule

//--- operand_store/weight_store.sv
//--------------------------------------------------------------------------
// weight store
// circular array of weights filled by load cycles and read in order,
// one weight per multiply, bias weights included
//--------------------------------------------------------------------------

`include "neuron_pe_consts.svh"

module weight_store
	import neuron_pe_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  pe_op_t   ctrl,
	input  pe_word_t data_in,
	input  pe_step_t step,
	output pe_word_t weight
);

	pe_word_t mem [`PE_WGT_DEPTH];

	wgt_idx_t wr_ptr;
	wgt_idx_t wr_ptr_nxt;
	wgt_idx_t rd_ptr;
	wgt_idx_t rd_ptr_nxt;
	logic     full;
	logic     load_en;
	logic     rd_adv;

	// loads arrive on ctrl directly, they never go through the counter
	// a load into a full store is dropped
	assign load_en = (ctrl == op_load) && !full;

	// every multiply-type commit consumes one weight
	assign rd_adv = step.commit && (step.op inside {op_ma, op_mab, op_bias});

	// pointer wrap at the end of the array
	always_comb
	begin
		if (wr_ptr == wgt_idx_t'(`PE_WGT_DEPTH - 1))
			wr_ptr_nxt = '0;
		else
			wr_ptr_nxt = wr_ptr + wgt_idx_t'(1);
		if (rd_ptr == wgt_idx_t'(`PE_WGT_DEPTH - 1))
			rd_ptr_nxt = '0;
		else
			rd_ptr_nxt = rd_ptr + wgt_idx_t'(1);
	end

	// pointers and full flag
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			full   <= 1'b0;
		end
		else
		begin
			if (load_en)
			begin
				wr_ptr <= wr_ptr_nxt;
				// full is sticky, weights are meant to be loaded once
				if (wr_ptr_nxt == rd_ptr)
					full <= 1'b1;
			end
			if (rd_adv)
				rd_ptr <= rd_ptr_nxt;
		end
	end

	// weight array
	always_ff @(posedge clock)
	begin
		if (load_en)
			mem[wr_ptr] <= data_in;
	end

	// current operand
	assign weight = mem[rd_ptr];

endmodule

//--- operand_store/input_buffer.sv
//--------------------------------------------------------------------------
// input buffer
// records the data of each direct multiply-add so that later weights
// can be applied to the same inputs, with a start bookmark for
// rewinding and a clear that starts a new input set
//--------------------------------------------------------------------------

`include "neuron_pe_consts.svh"

module input_buffer
	import neuron_pe_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  pe_word_t data_in,
	input  pe_step_t step,
	output pe_word_t replay
);

	pe_word_t mem [`PE_IN_DEPTH];

	in_idx_t wr_ptr;
	in_idx_t wr_ptr_nxt;
	in_idx_t rd_ptr;
	in_idx_t rd_ptr_nxt;
	// read position at the start of the current input set
	in_idx_t start_ptr;
	logic    full;
	logic    rec_en;

	// capture data on the first cycle of op_ma, while it is on the pins
	assign rec_en = step.issue && (step.op == op_ma) && !full;

	always_comb
	begin
		if (wr_ptr == in_idx_t'(`PE_IN_DEPTH - 1))
			wr_ptr_nxt = '0;
		else
			wr_ptr_nxt = wr_ptr + in_idx_t'(1);
		if (rd_ptr == in_idx_t'(`PE_IN_DEPTH - 1))
			rd_ptr_nxt = '0;
		else
			rd_ptr_nxt = rd_ptr + in_idx_t'(1);
	end

	//--------------------------------------------------------------------------
	// pointer updates, all on the commit cycle
	//--------------------------------------------------------------------------

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			start_ptr <= '0;
			full      <= 1'b0;
		end
		else if (step.commit)
		begin
			case (step.op)
				op_ma:
				begin
					// entry was written at issue, now make it visible
					if (!full)
					begin
						wr_ptr <= wr_ptr_nxt;
						if (wr_ptr_nxt == rd_ptr)
							full <= 1'b1;
					end
				end
				op_mab:
					rd_ptr <= rd_ptr_nxt;
				op_act:
					// replay the same inputs for the next neuron
					rd_ptr <= start_ptr;
				op_act_clr:
				begin
					// drop the recorded set, next op_ma starts a new one
					rd_ptr    <= wr_ptr;
					start_ptr <= wr_ptr;
					full      <= 1'b0;
				end
				default:
				begin
				end
			endcase
		end
	end

	// recorded data
	always_ff @(posedge clock)
	begin
		if (rec_en)
			mem[wr_ptr] <= data_in;
	end

	assign replay = mem[rd_ptr];

endmodule

//--- src/mac_unit.sv
//--------------------------------------------------------------------------
// multiply-accumulate unit
// picks the multiplier operand for the held opcode, registers the
// operand pair at issue and the product a cycle later, and folds the
// product into the neuron accumulator at commit
// arithmetic is signed 32-bit with wrap
//--------------------------------------------------------------------------

module mac_unit
	import neuron_pe_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  pe_word_t data_in,
	input  pe_word_t weight,
	input  pe_word_t replay,
	input  pe_step_t step,
	output pe_word_t acc
);

	pe_word_t op_sel;
	pe_word_t mul_a;
	pe_word_t mul_w;
	pe_word_t prod;
	logic     is_mult;
	logic     is_act;
	// product stage enable, one cycle behind issue
	logic     mul_pend;

	assign is_mult = step.op inside {op_ma, op_mab, op_bias};
	assign is_act  = step.op inside {op_act, op_act_clr};

	// multiplier operand
	// bias multiplies the weight by one
	always_comb
	begin
		case (step.op)
			op_ma:   op_sel = data_in;
			op_mab:  op_sel = replay;
			op_bias: op_sel = pe_word_t'(1);
			default: op_sel = '0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			mul_pend <= 1'b0;
		else
			mul_pend <= step.issue && is_mult;
	end

	//--------------------------------------------------------------------------
	// datapath stages
	//--------------------------------------------------------------------------

	// operand pair at issue
	always_ff @(posedge clock)
	begin
		if (step.issue && is_mult)
		begin
			mul_a <= op_sel;
			mul_w <= weight;
		end
	end

	// low 32 bits of the product
	always_ff @(posedge clock)
	begin
		if (mul_pend)
			prod <= mul_a * mul_w;
	end

	// accumulator
	// on activation the output buffer takes the old value on this edge
	always_ff @(posedge clock)
	begin
		if (reset)
			acc <= '0;
		else if (step.commit && is_mult)
			acc <= acc + prod;
		else if (step.commit && is_act)
			acc <= '0;
	end

endmodule

//--- src/output_buffer.sv
//--------------------------------------------------------------------------
// output buffer
// small FIFO of finished neuron values, written on activation commits
// and read one value per idle run while the controller asks for output
//--------------------------------------------------------------------------

`include "neuron_pe_consts.svh"

module output_buffer
	import neuron_pe_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  pe_step_t step,
	input  logic     output_ctrl,
	input  pe_word_t acc,
	output pe_word_t data_out
);

	pe_word_t mem [`PE_OUT_DEPTH];

	out_idx_t wr_ptr;
	out_idx_t wr_ptr_nxt;
	out_idx_t rd_ptr;
	out_idx_t rd_ptr_nxt;
	logic     full;
	logic     push;
	logic     pop;

	// both activation opcodes pass the accumulator through unchanged
	assign push = step.commit && (step.op inside {op_act, op_act_clr}) && !full;
	// pop at the end of an idle run with readout enabled
	assign pop  = step.commit && (step.op == op_idle) && output_ctrl;

	always_comb
	begin
		if (wr_ptr == out_idx_t'(`PE_OUT_DEPTH - 1))
			wr_ptr_nxt = '0;
		else
			wr_ptr_nxt = wr_ptr + out_idx_t'(1);
		if (rd_ptr == out_idx_t'(`PE_OUT_DEPTH - 1))
			rd_ptr_nxt = '0;
		else
			rd_ptr_nxt = rd_ptr + out_idx_t'(1);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			full   <= 1'b0;
		end
		else
		begin
			if (push)
			begin
				wr_ptr <= wr_ptr_nxt;
				if (wr_ptr_nxt == rd_ptr)
					full <= 1'b1;
			end
			// full stays set after a pop
			if (pop)
				rd_ptr <= rd_ptr_nxt;
		end
	end

	always_ff @(posedge clock)
	begin
		if (push)
			mem[wr_ptr] <= acc;
	end

	// head of the FIFO, always visible
	assign data_out = mem[rd_ptr];

endmodule

//--- src/neuron_pe.sv
//--------------------------------------------------------------------------
// neuron processing element
// one neuron node of a vector neural-network accelerator: weight store
// and input buffer feed the multiply-accumulate unit, finished values
// go to a small output buffer read out in idle cycles
//--------------------------------------------------------------------------

module neuron_pe
	import neuron_pe_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  pe_op_t   ctrl,
	input  logic     output_ctrl,
	input  pe_word_t data_in,
	output pe_word_t data_out,
	output logic     data_out_valid
);

	pe_step_t step;
	pe_word_t weight;
	pe_word_t replay;
	pe_word_t acc;

	// output is presented for the whole idle run while requested
	assign data_out_valid = output_ctrl && (ctrl == op_idle);

	op_sequencer i_op_sequencer (
		.clock (clock),
		.reset (reset),
		.ctrl  (ctrl),
		.step  (step)
	);

	//--------------------------------------------------------------------------
	// operand stores
	//--------------------------------------------------------------------------

	weight_store i_weight_store (
		.clock   (clock),
		.reset   (reset),
		.ctrl    (ctrl),
		.data_in (data_in),
		.step    (step),
		.weight  (weight)
	);

	input_buffer i_input_buffer (
		.clock   (clock),
		.reset   (reset),
		.data_in (data_in),
		.step    (step),
		.replay  (replay)
	);

	// accumulator and readout
	mac_unit i_mac_unit (
		.clock   (clock),
		.reset   (reset),
		.data_in (data_in),
		.weight  (weight),
		.replay  (replay),
		.step    (step),
		.acc     (acc)
	);

	output_buffer i_output_buffer (
		.clock       (clock),
		.reset       (reset),
		.step        (step),
		.output_ctrl (output_ctrl),
		.acc         (acc),
		.data_out    (data_out)
	);

endmodule

//--- verification/pe_ref_model.svh
//--------------------------------------------------------------------------
// reference model of the neuron element
// operation-level mirror of the weight store, input buffer, accumulator
// and output FIFO, included into the testbench module
//--------------------------------------------------------------------------

`ifndef PE_REF_MODEL_SVH
`define PE_REF_MODEL_SVH

// weight store image
pe_word_t wgt_mem [`PE_WGT_DEPTH];
int       wgt_wr;
int       wgt_rd;
bit       wgt_full;

// input buffer image, seen marks entries that hold recorded data
pe_word_t in_mem [`PE_IN_DEPTH];
bit       in_seen [`PE_IN_DEPTH];
int       in_wr;
int       in_rd;
int       in_start;
bit       in_full;

// neuron accumulator
pe_word_t acc_exp;

// output FIFO image
pe_word_t out_mem [`PE_OUT_DEPTH];
bit       out_seen [`PE_OUT_DEPTH];
int       out_wr;
int       out_rd;
bit       out_full;

// circular pointer step
function automatic int next_index(input int idx, input int depth);
	return (idx + 1) % depth;
endfunction

// signed 64-bit product cut down to its low word
function automatic pe_word_t low_product(input pe_word_t a, input pe_word_t b);
	longint full_prod;
	full_prod = longint'(a) * longint'(b);
	return pe_word_t'(full_prod[31:0]);
endfunction

function automatic void clear_model();
	wgt_wr   = 0;
	wgt_rd   = 0;
	wgt_full = 1'b0;
	in_wr    = 0;
	in_rd    = 0;
	in_start = 0;
	in_full  = 1'b0;
	acc_exp  = '0;
	out_wr   = 0;
	out_rd   = 0;
	out_full = 1'b0;
	for (int i = 0; i < `PE_IN_DEPTH; i++)
		in_seen[i] = 1'b0;
	for (int i = 0; i < `PE_OUT_DEPTH; i++)
		out_seen[i] = 1'b0;
endfunction

// one load cycle, dropped once the store has filled
function automatic void take_weight(input pe_word_t w);
	if (!wgt_full)
	begin
		wgt_mem[wgt_wr] = w;
		wgt_wr = next_index(wgt_wr, `PE_WGT_DEPTH);
		if (wgt_wr == wgt_rd)
			wgt_full = 1'b1;
	end
endfunction

// whole multiply-type operation: op_ma, op_mab or op_bias
function automatic void accumulate(input pe_op_t op, input pe_word_t d);
	pe_word_t operand;
	case (op)
		op_ma:   operand = d;
		op_mab:  operand = in_mem[in_rd];
		default: operand = pe_word_t'(1);
	endcase
	acc_exp = acc_exp + low_product(operand, wgt_mem[wgt_rd]);
	wgt_rd = next_index(wgt_rd, `PE_WGT_DEPTH);
	// direct data is recorded for later replay
	if (op == op_ma && !in_full)
	begin
		in_mem[in_wr]  = d;
		in_seen[in_wr] = 1'b1;
		in_wr = next_index(in_wr, `PE_IN_DEPTH);
		if (in_wr == in_rd)
			in_full = 1'b1;
	end
	if (op == op_mab)
		in_rd = next_index(in_rd, `PE_IN_DEPTH);
endfunction

// activation: push the neuron value, clear the sum, rewind or drop inputs
function automatic void close_neuron(input pe_op_t op);
	if (!out_full)
	begin
		out_mem[out_wr]  = acc_exp;
		out_seen[out_wr] = 1'b1;
		out_wr = next_index(out_wr, `PE_OUT_DEPTH);
		if (out_wr == out_rd)
			out_full = 1'b1;
	end
	acc_exp = '0;
	if (op == op_act)
		in_rd = in_start;
	else
	begin
		in_rd    = in_wr;
		in_start = in_wr;
		in_full  = 1'b0;
	end
endfunction

// replay only reads entries that were recorded at some point
function automatic bit replay_ready();
	return in_seen[in_rd];
endfunction

function automatic bit head_ready();
	return out_seen[out_rd];
endfunction

function automatic pe_word_t head_value();
	return out_mem[out_rd];
endfunction

// pop on the idle commit, the full flag stays as it is
function automatic void advance_head();
	out_rd = next_index(out_rd, `PE_OUT_DEPTH);
endfunction

`endif

//--- verification/neuron_pe_tb.sv
//--------------------------------------------------------------------------
// testbench for the neuron processing element
// loads weights, runs direct, replay and clear sequences, then a seeded
// random opcode mix, checking every readout against a reference model
//--------------------------------------------------------------------------

`include "neuron_pe_consts.svh"

module neuron_pe_tb
	import neuron_pe_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	logic        clock = 1'b0;
	logic        reset;
	pe_op_t      ctrl;
	logic        output_ctrl;
	pe_word_t    data_in;
	pe_word_t    data_out;
	logic        data_out_valid;
	int unsigned seed_ret;

	`include "pe_ref_model.svh"

	neuron_pe i_neuron_pe (
		.clock          (clock),
		.reset          (reset),
		.ctrl           (ctrl),
		.output_ctrl    (output_ctrl),
		.data_in        (data_in),
		.data_out       (data_out),
		.data_out_valid (data_out_valid)
	);

	// 100 ns clock period
	always #50 clock = ~clock;

	//--------------------------------------------------------------------------
	// checking and timing helpers
	//--------------------------------------------------------------------------

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "%s differs from the model", name);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timed out waiting for %s", what);
		$display("TESTBENCH FAILED");
		$fatal(1, "the DUT did not respond in time");
	endtask

	task automatic wait_edges(input int count);
		for (int i = 0; i < count; i++)
			@(posedge clock);
	endtask

	// inputs change just after a rising edge
	task automatic drive(input pe_op_t op, input pe_word_t d, input logic oc);
		@(posedge clock);
		ctrl        <= op;
		data_in     <= d;
		output_ctrl <= oc;
	endtask

	// three reset cycles, the model starts over with the DUT
	// weight contents survive in both
	task automatic reset_dut();
		@(posedge clock);
		reset       <= 1'b1;
		ctrl        <= op_nop;
		output_ctrl <= 1'b0;
		wait_edges(3);
		reset <= 1'b0;
		clear_model();
	endtask

	// one-cycle opcodes
	task automatic load_cycle(input pe_word_t w);
		drive(op_load, w, 1'b0);
		@(negedge clock);
		check_value("valid during load", 32'd0, {31'd0, data_out_valid});
		take_weight(w);
	endtask

	task automatic nop_cycle(input pe_word_t d, input logic oc);
		drive(op_nop, d, oc);
		@(negedge clock);
		check_value("valid during nop", 32'd0, {31'd0, data_out_valid});
	endtask

	// four-cycle operation, commit lands on the next drive edge
	task automatic run_timed(input pe_op_t op, input pe_word_t d, input logic oc,
		input string name);
		drive(op, d, oc);
		@(negedge clock);
		check_value({name, " valid"}, 32'd0, {31'd0, data_out_valid});
		wait_edges(`PE_OP_LAST);
		if (op == op_act || op == op_act_clr)
			close_neuron(op);
		else
			accumulate(op, d);
	endtask

	// idle run, with oc high the head is checked and then popped
	task automatic run_idle(input logic oc, input string name);
		int waited;
		drive(op_idle, pe_word_t'($urandom), oc);
		waited = 0;
		do
		begin
			@(negedge clock);
			waited++;
		end
		while (data_out_valid !== oc && waited < `PE_OP_LAST);
		if (data_out_valid !== oc)
			report_timeout({name, " output valid"});
		if (oc)
		begin
			check_value(name, head_value(), data_out);
			advance_head();
		end
		wait_edges(`PE_OP_LAST + 1 - waited);
	endtask

	//--------------------------------------------------------------------------
	// stimulus
	//--------------------------------------------------------------------------

	initial
	begin
		int unsigned pick;
		logic        oc;
		reset       = 1'b1;
		ctrl        = op_nop;
		output_ctrl = 1'b0;
		data_in     = '0;
		seed_ret    = $urandom(32'h7131dfcd);
		clear_model();
		wait_edges(3);
		reset <= 1'b0;

		// valid decode; the idle request is dropped before its commit
		nop_cycle('0, 1'b1);
		drive(op_idle, '0, 1'b0);
		@(negedge clock);
		check_value("idle without request", 32'd0, {31'd0, data_out_valid});
		drive(op_idle, '0, 1'b1);
		@(negedge clock);
		check_value("idle with request", 32'd1, {31'd0, data_out_valid});
		nop_cycle('0, 1'b0);

		// fill the weight store
		for (int i = 0; i < `PE_WGT_DEPTH; i++)
			load_cycle(pe_word_t'($urandom));

		// three products plus bias
		for (int i = 0; i < 3; i++)
			run_timed(op_ma, pe_word_t'($urandom), 1'b0, "direct multiply");
		run_timed(op_bias, '0, 1'b0, "bias");
		run_timed(op_act, '0, 1'b1, "activation");
		run_idle(1'b1, "first neuron");

		// same inputs against the next weights
		for (int i = 0; i < 3; i++)
			run_timed(op_mab, pe_word_t'($urandom), 1'b0, "replay");
		run_timed(op_act, '0, 1'b0, "activation");
		run_idle(1'b1, "replayed neuron");

		// clear drops the input set, extra loads hit a full store
		for (int i = 0; i < 2; i++)
			run_timed(op_ma, pe_word_t'($urandom), 1'b0, "multiply before clear");
		run_timed(op_act_clr, '0, 1'b0, "clearing activation");
		run_idle(1'b1, "cleared neuron");
		for (int i = 0; i < 3; i++)
			load_cycle(pe_word_t'($urandom));
		for (int i = 0; i < 2; i++)
			run_timed(op_ma, pe_word_t'($urandom), 1'b0, "multiply after clear");
		run_timed(op_act, '0, 1'b0, "activation");
		for (int i = 0; i < 2; i++)
			run_timed(op_mab, '0, 1'b0, "replay after clear");
		// four pushes fill the output buffer, the fifth is lost
		for (int i = 0; i < 4; i++)
			run_timed(op_act, '0, 1'b0, "activation");
		for (int i = 0; i < `PE_OUT_DEPTH; i++)
			run_idle(1'b1, "full output buffer");

		// full flags are sticky, start the random mix from empty stores
		reset_dut();

		// random opcode mix
		for (int n = 0; n < 300; n++)
		begin
			pick = $urandom_range(7, 0);
			oc   = 1'($urandom_range(1, 0));
			case (pick)
				0, 1, 2:
					run_timed(op_ma, pe_word_t'($urandom), oc, "random multiply");
				3:
				begin
					if (replay_ready())
						run_timed(op_mab, pe_word_t'($urandom), oc, "random replay");
					else
						run_timed(op_ma, pe_word_t'($urandom), oc, "random multiply");
				end
				4:
					run_timed(op_bias, pe_word_t'($urandom), oc, "random bias");
				5:
				begin
					if (oc)
						run_timed(op_act, pe_word_t'($urandom), oc, "random activation");
					else
						run_timed(op_act_clr, pe_word_t'($urandom), oc, "random clear");
				end
				6:
					run_idle(oc && head_ready(), "random readout");
				default:
				begin
					if (oc)
						load_cycle(pe_word_t'($urandom));
					else
						nop_cycle(pe_word_t'($urandom), 1'b1);
				end
			endcase
		end

		drive(op_nop, '0, 1'b0);
		wait_edges(2);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- neuron_pe.f
+incdir+common
+incdir+verification
common/neuron_pe_pkg.sv
src/op_sequencer.sv
operand_store/weight_store.sv
operand_store/input_buffer.sv
src/mac_unit.sv
src/output_buffer.sv
src/neuron_pe.sv
verification/neuron_pe_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the neuron_pe testbench with Verilator and run it
# the exit status is the simulator's, nonzero on any failure
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module neuron_pe_tb \
	-f neuron_pe.f --Mdir obj_dir &&
./obj_dir/Vneuron_pe_tb ||
exit 1
